// File: Makefile
TOP := exec_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	@out="$$(./obj_dir/sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: bench/exec_unit_assertions.sv
`timescale 1ns/1ps

module exec_unit_assertions (
    input logic              clk,
    input logic              rst_n,
    input alu_pkg::alu_req_t req,
    input logic              stall,
    input alu_pkg::hilo_t    hilo
);

    int stall_run = 0;      // consecutive stalled cycles
    int fail_count = 0;

    always @(posedge clk) begin
        if (!rst_n || !stall) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall_run + 1;
        end
    end

    stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_run <= alu_pkg::iter_count + 2))
        else begin
            $error("stall held longer than %0d cycles", alu_pkg::iter_count + 2);
            fail_count = fail_count + 1;
        end

    // pipeline must hold the request through the stall and the ready cycle
    req_held: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(req))
        else begin
            $error("request changed while stalled");
            fail_count = fail_count + 1;
        end

    hilo_held: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(hilo))
        else begin
            $error("hilo changed while stalled");
            fail_count = fail_count + 1;
        end

endmodule

// File: bench/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;

    localparam int     reset_cycles = 5;
    localparam int     n_random     = 80;
    localparam int     long_stall   = alu_pkg::iter_count + 2;  // opcode cycle up to ready
    localparam longint s32_max      = 64'sd2147483647;
    localparam longint s32_min      = -64'sd2147483648;

    typedef struct packed {
        alu_pkg::alu_req_t req;
        logic [31:0]       cp0;
    } test_t;

    typedef struct packed {
        logic [31:0]    y;
        logic           ov;
        alu_pkg::hilo_t hilo;
    } expect_t;

    logic                        clk;
    logic                        rst_n;
    alu_pkg::alu_req_t           req;
    logic [alu_pkg::xlen-1:0]    cp0_data;
    logic [alu_pkg::xlen-1:0]    y;
    logic                        overflow;
    logic                        stall;
    alu_pkg::hilo_t              hilo;

    test_t                       tests[$];
    alu_pkg::hilo_t              model_hilo;
    alu_pkg::alu_req_t           last_long;
    logic                        last_long_valid;
    expect_t                     exp_now;
    int                          exp_stall;
    string                       cur_name;
    int                          issued = 0;
    int                          done = 0;
    int                          cycle_limit = 0;
    int                          cycles = 0;
    int                          stall_cycles = 0;
    logic                        y_seen = 1'b0;
    int                          test_errs = 0;
    int                          err_count = 0;
    int                          pass_count = 0;
    int unsigned                 seed_ret;
    logic [alu_pkg::aluop_w-1:0] op_pool [32];

    exec_unit dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .cp0_data (cp0_data),
        .y        (y),
        .overflow (overflow),
        .stall    (stall),
        .hilo     (hilo)
    );

    bind exec_unit exec_unit_assertions u_assert (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .stall (stall),
        .hilo  (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic is_long_op(input logic [alu_pkg::aluop_w-1:0] op);
        return (op == alu_pkg::op_mult) || (op == alu_pkg::op_multu) ||
               (op == alu_pkg::op_div) || (op == alu_pkg::op_divu);
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = $urandom;
        if ($urandom_range(0, 3) == 0) begin     // signed and unsigned limits
            case ($urandom_range(0, 3))
                0:       r = 32'h7fffffff;
                1:       r = 32'h80000000;
                2:       r = 32'hffffffff;
                default: r = 32'h00000000;
            endcase
        end
        return r;
    endfunction

    function automatic expect_t ref_exec(input logic [7:0] op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] cp0,
                                         input alu_pkg::hilo_t hl);
        expect_t e;
        longint  sa;
        longint  sb;
        longint  wide;
        sa     = longint'($signed(a));
        sb     = longint'($signed(b));
        e.y    = '0;
        e.ov   = 1'b0;
        e.hilo = hl;
        case (op)
            alu_pkg::op_add,
            alu_pkg::op_sub: begin
                wide = (op == alu_pkg::op_add) ? sa + sb : sa - sb;
                e.y  = wide[31:0];
                e.ov = (wide > s32_max) || (wide < s32_min);  // left the 32-bit range
            end
            alu_pkg::op_addu:  e.y = a + b;
            alu_pkg::op_subu:  e.y = a - b;
            alu_pkg::op_slt,
            alu_pkg::op_slti:  e.y = (sa < sb) ? 32'd1 : 32'd0;
            alu_pkg::op_sltu,
            alu_pkg::op_sltiu: e.y = (a < b) ? 32'd1 : 32'd0;
            alu_pkg::op_and:   e.y = a & b;
            alu_pkg::op_or:    e.y = a | b;
            alu_pkg::op_nor:   e.y = ~(a | b);
            alu_pkg::op_xor:   e.y = a ^ b;
            alu_pkg::op_lui:   e.y = {b[15:0], 16'h0000};
            alu_pkg::op_sll,
            alu_pkg::op_sllv:  e.y = b << a[4:0];
            alu_pkg::op_srl,
            alu_pkg::op_srlv:  e.y = b >> a[4:0];
            alu_pkg::op_sra,
            alu_pkg::op_srav: begin
                e.y = b >> a[4:0];
                if (b[31]) begin
                    e.y = e.y | ~(32'hffffffff >> a[4:0]);    // sign fill from the top
                end
            end
            alu_pkg::op_mult:  e.hilo = sa * sb;
            alu_pkg::op_multu: e.hilo = {32'h0, a} * {32'h0, b};
            alu_pkg::op_div: begin
                wide      = sa / sb;             // truncates toward zero
                e.hilo.lo = wide[31:0];
                wide      = sa % sb;
                e.hilo.hi = wide[31:0];
            end
            alu_pkg::op_divu: begin
                e.hilo.lo = a / b;
                e.hilo.hi = a % b;
            end
            alu_pkg::op_mthi:  e.hilo.hi = a;
            alu_pkg::op_mtlo:  e.hilo.lo = a;
            alu_pkg::op_mfhi:  e.y = hl.hi;
            alu_pkg::op_mflo:  e.y = hl.lo;
            alu_pkg::op_mfc0:  e.y = cp0;
            default:           e.y = '0;
        endcase
        if (is_long_op(op)) begin
            e.y = e.hilo.lo;
        end
        return e;
    endfunction

    task automatic add_test(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
        test_t t;
        t.req.op = op;
        t.req.a  = a;
        t.req.b  = b;
        t.cp0    = $urandom;
        tests.push_back(t);
    endtask

    task automatic build_tests();
        logic [alu_pkg::aluop_w-1:0] op;
        logic [31:0]                 a;
        logic [31:0]                 b;
        logic [31:0]                 r;
        logic [4:0]                  pick;
        add_test(alu_pkg::op_mfhi, 32'h0, 32'h0);   // HI/LO cleared by reset
        add_test(alu_pkg::op_mflo, 32'h0, 32'h0);
        add_test(alu_pkg::op_add, 32'h7fffffff, 32'h00000001);
        add_test(alu_pkg::op_add, 32'h80000000, 32'hffffffff);
        add_test(alu_pkg::op_add, 32'h7fffffff, 32'hffffffff);
        add_test(alu_pkg::op_sub, 32'h80000000, 32'h00000001);
        add_test(alu_pkg::op_sub, 32'h7fffffff, 32'hffffffff);
        add_test(alu_pkg::op_addu, 32'h7fffffff, 32'h00000001);
        add_test(alu_pkg::op_subu, 32'h80000000, 32'h00000001);
        add_test(alu_pkg::op_mult, 32'hffffffff, 32'h7fffffff);
        add_test(alu_pkg::op_mult, 32'h80000000, 32'h80000000);
        add_test(alu_pkg::op_multu, 32'hffffffff, 32'hffffffff);
        add_test(alu_pkg::op_div, 32'hfffffff9, 32'h00000002);
        add_test(alu_pkg::op_div, 32'h00000007, 32'hfffffffe);
        add_test(alu_pkg::op_divu, 32'hffffffff, 32'h00000010);
        add_test(alu_pkg::op_mthi, 32'h12345678, 32'h0);
        add_test(alu_pkg::op_mtlo, 32'h9abcdef0, 32'h0);
        add_test(alu_pkg::op_mfhi, 32'h0, 32'h0);
        add_test(alu_pkg::op_mflo, 32'h0, 32'h0);
        add_test(alu_pkg::op_mfc0, 32'h0, 32'h0);
        // repeats come from the result cache
        add_test(alu_pkg::op_div, 32'h00000064, 32'h00000007);
        add_test(alu_pkg::op_div, 32'h00000064, 32'h00000007);
        add_test(alu_pkg::op_div, 32'h000003e8, 32'hfffffffd);
        add_test(alu_pkg::op_mult, 32'h00001234, 32'h00005678);
        add_test(alu_pkg::op_mult, 32'h00001234, 32'h00005678);
        for (int i = 0; i < n_random; i++) begin
            pick = 5'($urandom);
            op   = op_pool[pick];
            a    = rand_operand();
            b    = rand_operand();
            r    = $urandom;
            if ((op == alu_pkg::op_slti) || (op == alu_pkg::op_sltiu)) begin
                b = {{16{r[15]}}, r[15:0]};          // sign-extended immediate
            end
            if (((op == alu_pkg::op_div) || (op == alu_pkg::op_divu)) && (b == 32'h0)) begin
                b = r | 32'h1;
            end
            add_test(op, a, b);
        end
    endtask

    task automatic run_test(input int idx, input test_t t);
        expect_t e;
        @(posedge clk);
        req      <= t.req;
        cp0_data <= t.cp0;
        e         = ref_exec(t.req.op, t.req.a, t.req.b, t.cp0, model_hilo);
        exp_now   = e;
        exp_stall = 0;
        if (is_long_op(t.req.op) && !(last_long_valid && (last_long == t.req))) begin
            exp_stall = long_stall;
        end
        cur_name = $sformatf("test %0d op %02h", idx, t.req.op);
        issued   = issued + 1;
        wait (done == issued);
        model_hilo = e.hilo;
        if (is_long_op(t.req.op)) begin
            last_long       = t.req;
            last_long_valid = 1'b1;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && (issued != done)) begin
            if (!y_seen && stall) begin
                stall_cycles = stall_cycles + 1;
            end else if (!y_seen) begin
                if (y !== exp_now.y) begin
                    $display("[ERROR] %s y: expected %h, actual %h", cur_name, exp_now.y, y);
                    test_errs = test_errs + 1;
                end
                if (overflow !== exp_now.ov) begin
                    $display("[ERROR] %s overflow: expected %b, actual %b",
                             cur_name, exp_now.ov, overflow);
                    test_errs = test_errs + 1;
                end
                if (stall_cycles != exp_stall) begin
                    $display("[ERROR] %s stall cycles: expected %0d, actual %0d",
                             cur_name, exp_stall, stall_cycles);
                    test_errs = test_errs + 1;
                end
                y_seen = 1'b1;
            end else begin
                // same request held once more
                if (stall) begin
                    $display("[ERROR] %s held stall: expected 0, actual %b", cur_name, stall);
                    test_errs = test_errs + 1;
                end
                if (y !== exp_now.y) begin
                    $display("[ERROR] %s held y: expected %h, actual %h", cur_name, exp_now.y, y);
                    test_errs = test_errs + 1;
                end
                if (hilo !== exp_now.hilo) begin
                    $display("[ERROR] %s hilo: expected %h, actual %h",
                             cur_name, exp_now.hilo, hilo);
                    test_errs = test_errs + 1;
                end
                if (test_errs == 0) begin
                    pass_count = pass_count + 1;
                    $display("%s ok", cur_name);
                end else begin
                    $display("%s failed with %0d errors", cur_name, test_errs);
                end
                err_count    = err_count + test_errs;
                test_errs    = 0;
                stall_cycles = 0;
                y_seen       = 1'b0;
                done         = done + 1;
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: tests still running after %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed_ret        = $urandom(32'hdbba28a7);
        req             = '0;
        cp0_data        = '0;
        rst_n           = 1'b0;
        model_hilo      = '0;
        last_long       = '0;
        last_long_valid = 1'b0;
        op_pool = '{alu_pkg::op_add, alu_pkg::op_addu, alu_pkg::op_sub, alu_pkg::op_subu,
                    alu_pkg::op_slt, alu_pkg::op_sltu, alu_pkg::op_slti, alu_pkg::op_sltiu,
                    alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_nor, alu_pkg::op_xor,
                    alu_pkg::op_lui, alu_pkg::op_sll, alu_pkg::op_sllv, alu_pkg::op_srl,
                    alu_pkg::op_srlv, alu_pkg::op_sra, alu_pkg::op_srav, alu_pkg::op_mult,
                    alu_pkg::op_multu, alu_pkg::op_div, alu_pkg::op_divu, alu_pkg::op_mthi,
                    alu_pkg::op_mtlo, alu_pkg::op_mfhi, alu_pkg::op_mflo, alu_pkg::op_mfc0,
                    alu_pkg::op_nop, alu_pkg::op_mult, alu_pkg::op_div, alu_pkg::op_divu};
        build_tests();
        cycle_limit = tests.size() * 40 + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        foreach (tests[i]) begin
            run_test(i, tests[i]);
        end
        $display("%0d tests, %0d passed, %0d failed checks, %0d assertion failures",
                 tests.size(), pass_count, err_count, dut0.u_assert.fail_count);
        if ((err_count == 0) && (dut0.u_assert.fail_count == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: common/alu_pkg.sv
package alu_pkg;

    localparam int xlen       = 32;
    localparam int aluop_w    = 8;
    localparam int iter_count = 32;               // iterations of mul and div
    localparam int cnt_w      = $clog2(iter_count);

    localparam logic [aluop_w-1:0] op_nop   = 8'h00;
    localparam logic [aluop_w-1:0] op_add   = 8'h01;
    localparam logic [aluop_w-1:0] op_addu  = 8'h02;
    localparam logic [aluop_w-1:0] op_sub   = 8'h03;
    localparam logic [aluop_w-1:0] op_subu  = 8'h04;
    localparam logic [aluop_w-1:0] op_slt   = 8'h05;
    localparam logic [aluop_w-1:0] op_sltu  = 8'h06;
    localparam logic [aluop_w-1:0] op_slti  = 8'h07;
    localparam logic [aluop_w-1:0] op_sltiu = 8'h08;
    localparam logic [aluop_w-1:0] op_and   = 8'h10;
    localparam logic [aluop_w-1:0] op_or    = 8'h11;
    localparam logic [aluop_w-1:0] op_nor   = 8'h12;
    localparam logic [aluop_w-1:0] op_xor   = 8'h13;
    localparam logic [aluop_w-1:0] op_lui   = 8'h14;
    localparam logic [aluop_w-1:0] op_sll   = 8'h20;
    localparam logic [aluop_w-1:0] op_sllv  = 8'h21;
    localparam logic [aluop_w-1:0] op_srl   = 8'h22;
    localparam logic [aluop_w-1:0] op_srlv  = 8'h23;
    localparam logic [aluop_w-1:0] op_sra   = 8'h24;
    localparam logic [aluop_w-1:0] op_srav  = 8'h25;
    localparam logic [aluop_w-1:0] op_mult  = 8'h30;
    localparam logic [aluop_w-1:0] op_multu = 8'h31;
    localparam logic [aluop_w-1:0] op_div   = 8'h32;
    localparam logic [aluop_w-1:0] op_divu  = 8'h33;
    localparam logic [aluop_w-1:0] op_mthi  = 8'h40;
    localparam logic [aluop_w-1:0] op_mtlo  = 8'h41;
    localparam logic [aluop_w-1:0] op_mfhi  = 8'h42;
    localparam logic [aluop_w-1:0] op_mflo  = 8'h43;
    localparam logic [aluop_w-1:0] op_mfc0  = 8'h50;

    // request from the pipeline
    typedef struct packed {
        logic [aluop_w-1:0] op;
        logic [xlen-1:0]    a;
        logic [xlen-1:0]    b;
    } alu_req_t;

    typedef struct packed {
        logic [xlen-1:0] hi;
        logic [xlen-1:0] lo;
    } hilo_t;

    // operands for mul and div
    typedef struct packed {
        logic            signed_op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } long_req_t;

    // shared by both iterative units
    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_fix
    } iter_state_t;

endpackage

// File: div/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  alu_pkg::long_req_t req,
    output alu_pkg::hilo_t     result,
    output logic               ready
);

    alu_pkg::iter_state_t          state;
    logic [alu_pkg::cnt_w-1:0]     cnt;
    logic [alu_pkg::xlen-1:0]      a_mag;
    logic [alu_pkg::xlen-1:0]      b_mag;
    logic [alu_pkg::xlen-1:0]      dvsr;
    logic [alu_pkg::xlen-1:0]      quo;
    logic [alu_pkg::xlen-1:0]      rem;
    logic [alu_pkg::xlen:0]        trial;
    logic [alu_pkg::xlen:0]        trial_diff;
    logic                          trial_ge;
    logic                          q_neg;
    logic                          r_neg;

    assign a_mag = (req.signed_op && req.a[31]) ? -req.a : req.a;
    assign b_mag = (req.signed_op && req.b[31]) ? -req.b : req.b;

    // shift next dividend bit into the partial remainder
    assign trial      = {rem, quo[alu_pkg::xlen-1]};
    assign trial_diff = trial - {1'b0, dvsr};
    assign trial_ge   = trial >= {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= alu_pkg::st_idle;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state)
                alu_pkg::st_idle: if (start) begin
                    state <= alu_pkg::st_busy;
                    cnt   <= '0;
                end
                alu_pkg::st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == alu_pkg::cnt_w'(alu_pkg::iter_count - 1)) state <= alu_pkg::st_fix;
                end
                alu_pkg::st_fix: begin
                    state <= alu_pkg::st_idle;
                    ready <= 1'b1;
                end
                default: state <= alu_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            alu_pkg::st_idle: if (start) begin
                quo   <= a_mag;         // dividend shifts out as quotient shifts in
                dvsr  <= b_mag;
                rem   <= '0;
                q_neg <= req.signed_op && (req.a[31] ^ req.b[31]);
                r_neg <= req.signed_op && req.a[31];
            end
            alu_pkg::st_busy: begin
                if (trial_ge) begin
                    rem <= trial_diff[alu_pkg::xlen-1:0];
                end else begin
                    rem <= trial[alu_pkg::xlen-1:0];   // restore
                end
                quo <= {quo[alu_pkg::xlen-2:0], trial_ge};
            end
            alu_pkg::st_fix: begin
                result.hi <= r_neg ? -rem : rem;   // remainder follows dividend sign
                result.lo <= q_neg ? -quo : quo;
            end
            default: ;
        endcase
    end

endmodule

// File: flist.f
common/alu_pkg.sv
mul/mul_unit.sv
div/div_unit.sv
logic/hilo_reg.sv
logic/alu_master.sv
logic/exec_unit.sv
bench/exec_unit_assertions.sv
bench/exec_unit_tb.sv

// File: logic/alu_master.sv
`timescale 1ns/1ps

module alu_master (
    input  logic                       clk,
    input  logic                       rst_n,
    input  alu_pkg::alu_req_t          req,
    input  logic [alu_pkg::xlen-1:0]   cp0_data,
    input  alu_pkg::hilo_t             hilo,
    input  logic                       mul_ready,
    input  logic                       div_ready,
    input  alu_pkg::hilo_t             mul_result,
    input  alu_pkg::hilo_t             div_result,
    output logic [alu_pkg::xlen-1:0]   y,
    output logic                       overflow,
    output logic                       stall,
    output logic                       mul_start,
    output logic                       div_start,
    output alu_pkg::long_req_t         long_req,
    output logic                       hilo_we,
    output alu_pkg::hilo_t             hilo_wdata
);

    logic [alu_pkg::xlen-1:0] a;
    logic [alu_pkg::xlen-1:0] b;
    logic [alu_pkg::xlen-1:0] sum;
    logic [alu_pkg::xlen-1:0] diff;
    logic                     lt_s;
    logic                     lt_u;
    logic                     is_mul;
    logic                     is_div;
    logic                     long_done;
    alu_pkg::hilo_t           long_result;

    logic                     cache_valid;
    alu_pkg::alu_req_t        cache_req;
    alu_pkg::hilo_t           cache_result;
    logic                     cache_hit;

    assign a    = req.a;
    assign b    = req.b;
    assign sum  = a + b;
    assign diff = a - b;
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    assign is_mul = (req.op == alu_pkg::op_mult) || (req.op == alu_pkg::op_multu);
    assign is_div = (req.op == alu_pkg::op_div) || (req.op == alu_pkg::op_divu);

    assign long_req.signed_op = (req.op == alu_pkg::op_mult) || (req.op == alu_pkg::op_div);
    assign long_req.a         = a;
    assign long_req.b         = b;

    // cache only ever holds mul/div requests
    assign cache_hit = cache_valid && (req == cache_req);

    assign long_done   = (is_mul && mul_ready) || (is_div && div_ready);
    assign long_result = is_mul ? mul_result : div_result;

    // start stays high until ready comes back
    assign mul_start = is_mul && !mul_ready && !cache_hit;
    assign div_start = is_div && !div_ready && !cache_hit;
    assign stall     = mul_start || div_start;

    always_comb begin
        y          = '0;
        overflow   = 1'b0;
        hilo_we    = 1'b0;
        hilo_wdata = hilo;
        case (req.op)
            alu_pkg::op_add: begin
                y        = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            alu_pkg::op_addu: y = sum;
            alu_pkg::op_sub: begin
                y        = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            alu_pkg::op_subu: y = diff;
            alu_pkg::op_slt,
            alu_pkg::op_slti:  y[0] = lt_s;     // b already sign-extended for imm forms
            alu_pkg::op_sltu,
            alu_pkg::op_sltiu: y[0] = lt_u;
            alu_pkg::op_and:   y = a & b;
            alu_pkg::op_or:    y = a | b;
            alu_pkg::op_nor:   y = ~(a | b);
            alu_pkg::op_xor:   y = a ^ b;
            alu_pkg::op_lui:   y = {b[15:0], 16'h0000};
            alu_pkg::op_sll,
            alu_pkg::op_sllv:  y = b << a[4:0];
            alu_pkg::op_srl,
            alu_pkg::op_srlv:  y = b >> a[4:0];
            alu_pkg::op_sra,
            alu_pkg::op_srav:  y = $signed(b) >>> a[4:0];
            alu_pkg::op_mult,
            alu_pkg::op_multu,
            alu_pkg::op_div,
            alu_pkg::op_divu: begin
                if (long_done) begin
                    y          = long_result.lo;
                    hilo_we    = 1'b1;
                    hilo_wdata = long_result;
                end else if (cache_hit) begin
                    y          = cache_result.lo;   // no restart
                    hilo_we    = 1'b1;
                    hilo_wdata = cache_result;
                end
            end
            alu_pkg::op_mthi: begin
                hilo_we       = 1'b1;
                hilo_wdata.hi = a;
            end
            alu_pkg::op_mtlo: begin
                hilo_we       = 1'b1;
                hilo_wdata.lo = a;
            end
            alu_pkg::op_mfhi:  y = hilo.hi;
            alu_pkg::op_mflo:  y = hilo.lo;
            alu_pkg::op_mfc0:  y = cp0_data;
            alu_pkg::op_nop:   y = '0;
            default:           y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cache_valid <= 1'b0;
        end else if (long_done) begin
            cache_valid <= 1'b1;
        end
    end

    // last finished long op and its result
    always_ff @(posedge clk) begin
        if (long_done) begin
            cache_req    <= req;
            cache_result <= long_result;
        end
    end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  alu_pkg::alu_req_t         req,
    input  logic [alu_pkg::xlen-1:0]  cp0_data,
    output logic [alu_pkg::xlen-1:0]  y,
    output logic                      overflow,
    output logic                      stall,
    output alu_pkg::hilo_t            hilo
);

    logic               mul_start;
    logic               div_start;
    logic               mul_ready;
    logic               div_ready;
    alu_pkg::hilo_t     mul_result;
    alu_pkg::hilo_t     div_result;
    alu_pkg::long_req_t long_req;     // shared by both units
    logic               hilo_we;
    alu_pkg::hilo_t     hilo_wdata;

    alu_master u_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cp0_data   (cp0_data),
        .hilo       (hilo),
        .mul_ready  (mul_ready),
        .div_ready  (div_ready),
        .mul_result (mul_result),
        .div_result (div_result),
        .y          (y),
        .overflow   (overflow),
        .stall      (stall),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .long_req   (long_req),
        .hilo_we    (hilo_we),
        .hilo_wdata (hilo_wdata)
    );

    mul_unit u_mul (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (mul_start),
        .req    (long_req),
        .result (mul_result),
        .ready  (mul_ready)
    );

    div_unit u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (div_start),
        .req    (long_req),
        .result (div_result),
        .ready  (div_ready)
    );

    hilo_reg u_hilo (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (hilo_we),
        .wdata (hilo_wdata),
        .hilo  (hilo)
    );

endmodule

// File: logic/hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           we,
    input  alu_pkg::hilo_t wdata,
    output alu_pkg::hilo_t hilo
);

    // architectural HI/LO
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hilo <= '0;
        end else if (we) begin
            hilo <= wdata;
        end
    end

endmodule

// File: mul/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  alu_pkg::long_req_t req,
    output alu_pkg::hilo_t     result,
    output logic               ready
);

    alu_pkg::iter_state_t          state;
    logic [alu_pkg::cnt_w-1:0]     cnt;
    logic [alu_pkg::xlen-1:0]      a_mag;
    logic [alu_pkg::xlen-1:0]      b_mag;
    logic [2*alu_pkg::xlen-1:0]    mcand;
    logic [alu_pkg::xlen-1:0]      mplier;
    logic [2*alu_pkg::xlen-1:0]    acc;
    logic                          negate;

    assign a_mag = (req.signed_op && req.a[31]) ? -req.a : req.a;
    assign b_mag = (req.signed_op && req.b[31]) ? -req.b : req.b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= alu_pkg::st_idle;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state)
                alu_pkg::st_idle: if (start) begin
                    state <= alu_pkg::st_busy;
                    cnt   <= '0;
                end
                alu_pkg::st_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == alu_pkg::cnt_w'(alu_pkg::iter_count - 1)) state <= alu_pkg::st_fix;
                end
                alu_pkg::st_fix: begin
                    state <= alu_pkg::st_idle;
                    ready <= 1'b1;
                end
                default: state <= alu_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            alu_pkg::st_idle: if (start) begin
                mcand  <= {{alu_pkg::xlen{1'b0}}, a_mag};
                mplier <= b_mag;
                acc    <= '0;
                negate <= req.signed_op && (req.a[31] ^ req.b[31]);
            end
            alu_pkg::st_busy: begin
                if (mplier[0]) acc <= acc + mcand;  // one partial product per cycle
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            alu_pkg::st_fix: result <= negate ? -acc : acc;
            default: ;
        endcase
    end

endmodule
